//--- all.f
idmaPkg.sv
idmaMemIf.sv
idmaRegs.sv
idmaHostSeq.sv
idmaMem.sv
idmaTop.sv
idmaMonitor.sv
idmaTiming_checker.sv
idmaTb.sv

//--- idmaHostSeq.sv
`timescale 1ns/1ps

module idmaHostSeq import idmaPkg::*; (
  input  logic DSPCLK,
  input  logic RST,
  input  logic isN,
  input  logic ialN,
  input  logic irdN,
  input  logic iwrN,
  input  logic [15:0] iadIn,
  input  logic [2:0] drWait,
  input  logic [2:0] dwWait,
  input  logic [AddrBits-1:0] ctlAddr,
  input  logic pmSel,
  input  logic [OvlBits-1:0] ovl,
  output logic ldCtl,
  output logic ldOvl,
  output logic incAddr,
  output logic [15:0] latchWord,
  output logic iackN,
  output logic [15:0] iadOut,
  output logic iadOe,
  idmaMemIf.seq mem
);

  logic isS;
  logic ialS;
  logic irdS;
  logic iwrS;
  logic [15:0] iadS;
  logic rdCmd;
  logic wrCmd;
  logic alCmd;
  logic rdCmdD1;
  logic wrCmdD1;
  logic alCmdD1;
  logic rdBeg;
  logic wrBeg;
  logic alBeg;
  CycState state;
  WordPhase phase;
  logic [2:0] waitCnt;
  logic cycRd;
  logic reqAfter;
  logic cycEnd;
  logic outLow;
  logic [15:0] tmpHigh;
  logic [7:0] tmpLow;

  // Strobe sampling
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      isS <= 1'b1;
      ialS <= 1'b1;
      irdS <= 1'b1;
      iwrS <= 1'b1;
      rdCmdD1 <= 1'b0;
      wrCmdD1 <= 1'b0;
      alCmdD1 <= 1'b0;
    end else begin
      isS <= isN;
      ialS <= ialN;
      irdS <= irdN;
      iwrS <= iwrN;
      rdCmdD1 <= rdCmd;
      wrCmdD1 <= wrCmd;
      alCmdD1 <= alCmd;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (!isN) begin
      iadS <= iadIn;  // Bus word while selected
    end
  end

  assign rdCmd = !isS && !irdS;
  assign wrCmd = !isS && !iwrS;
  assign alCmd = !isS && !ialS;
  assign rdBeg = rdCmd && !rdCmdD1;
  assign wrBeg = wrCmd && !wrCmdD1;
  assign alBeg = alCmd && !alCmdD1;

  // Address latch decode with registers loading a cycle later
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      ldCtl <= 1'b0;
      ldOvl <= 1'b0;
    end else begin
      ldCtl <= alBeg && !iadS[CtlDirBit];
      ldOvl <= alBeg && iadS[CtlDirBit];
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (alBeg) begin
      latchWord <= iadS;
    end
  end

  // Low program-half write is the only wait step that then requests
  assign reqAfter = !cycRd && (phase == PhaseLow);
  assign cycEnd = (state == CycReq && mem.dsAck) ||
                  (state == CycWait && waitCnt == 3'd0 && !reqAfter);
  assign incAddr = cycEnd && (!pmSel || phase == PhaseLow);

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      state <= CycIdle;
      waitCnt <= 3'd0;
      cycRd <= 1'b0;
      iackN <= 1'b0;
    end else begin
      case (state)
        CycIdle: begin
          if (rdBeg || wrBeg) begin
            iackN <= 1'b1;
            cycRd <= rdBeg;
            if (!pmSel || (rdBeg && phase == PhaseHigh)) begin
              state <= CycReq;
            end else begin
              state <= CycWait;
              waitCnt <= rdBeg ? drWait : dwWait;
            end
          end
        end
        CycWait: begin
          if (waitCnt != 3'd0) begin
            waitCnt <= waitCnt - 3'd1;
          end else if (reqAfter) begin
            state <= CycReq;
          end else begin
            state <= CycDone;
          end
        end
        CycReq: begin
          if (mem.dsAck) begin
            state <= CycDone;
          end
        end
        default: state <= CycIdle;  // CycDone
      endcase
      if (cycEnd) begin
        iackN <= 1'b0;
      end
    end
  end

  // Word phase toggle
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      phase <= PhaseHigh;
    end else if (ldCtl || ldOvl) begin
      phase <= PhaseHigh;
    end else if (cycEnd && pmSel) begin
      phase <= (phase == PhaseHigh) ? PhaseLow : PhaseHigh;
    end
  end

  // Temporary registers that assemble or split the 24-bit word
  always_ff @(posedge DSPCLK) begin
    if (wrBeg && state == CycIdle) begin
      if (pmSel && phase == PhaseLow) begin
        tmpLow <= iadS[7:0];
      end else begin
        tmpHigh <= iadS;
      end
    end else if (cycEnd && cycRd) begin
      if (!pmSel) begin
        tmpHigh <= mem.rdata[15:0];
      end else if (phase == PhaseHigh) begin
        tmpHigh <= mem.rdata[23:8];
        tmpLow <= mem.rdata[7:0];  // Served by the low-half read
      end
    end
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      outLow <= 1'b0;
    end else if (cycEnd && cycRd) begin
      outLow <= pmSel && phase == PhaseLow;
    end
  end

  assign iadOut = outLow ? {8'h00, tmpLow} : tmpHigh;
  assign iadOe = rdCmd || (cycRd && state != CycIdle);

  assign mem.dsReq = (state == CycReq);
  assign mem.toPm = pmSel;
  assign mem.wrEn = !cycRd;
  assign mem.addr = ctlAddr;
  assign mem.page = ovl[PmPageBits-1:0];
  assign mem.wdata = pmSel ? {tmpHigh, tmpLow} : {8'h00, tmpHigh};

endmodule

//--- idmaMem.sv
`timescale 1ns/1ps

module idmaMem import idmaPkg::*; (
  input  logic DSPCLK,
  input  logic RST,
  input  logic coreBusy,
  idmaMemIf.mem mem
);

  logic granted;
  logic [$clog2(DmDepth)-1:0] dmIdx;
  logic [PmPageBits+PmAddrBits-1:0] pmIdx;
  logic [15:0] dmArr [DmDepth];
  logic [23:0] pmArr [2**(PmPageBits+PmAddrBits)];

  // Steal arbiter
  // The core owns memory while busy, so the grant waits for an idle cycle
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      granted <= 1'b0;
    end else if (mem.dsAck) begin
      granted <= 1'b1;  // One grant per request
    end else if (!mem.dsReq) begin
      granted <= 1'b0;
    end
  end

  assign mem.dsAck = mem.dsReq && !coreBusy && !granted;

  assign dmIdx = mem.addr[$clog2(DmDepth)-1:0];
  assign pmIdx = {mem.page, mem.addr[PmAddrBits-1:0]};  // Overlay page on top

  // Read data valid in the grant cycle
  assign mem.rdata = mem.toPm ? pmArr[pmIdx] : {8'h00, dmArr[dmIdx]};

  always_ff @(posedge DSPCLK) begin
    if (mem.dsAck && mem.wrEn) begin
      if (mem.toPm) begin
        pmArr[pmIdx] <= mem.wdata;
      end else begin
        dmArr[dmIdx] <= mem.wdata[15:0];
      end
    end
  end

endmodule

//--- idmaMemIf.sv
`timescale 1ns/1ps

interface idmaMemIf import idmaPkg::*; ();

  logic dsReq;  // Steal request level
  logic toPm;   // Low selects data memory
  logic wrEn;
  logic [AddrBits-1:0] addr;
  logic [PmPageBits-1:0] page;
  logic [23:0] wdata;
  logic dsAck;  // One-cycle grant
  logic [23:0] rdata;

  modport seq (
    output dsReq, toPm, wrEn, addr, page, wdata,
    input  dsAck, rdata
  );

  modport mem (
    input  dsReq, toPm, wrEn, addr, page, wdata,
    output dsAck, rdata
  );

endinterface

//--- idmaMonitor.sv
`timescale 1ns/1ps

module idmaMonitor (
  input  logic DSPCLK,
  input  logic RST,
  input  logic chkValid,
  input  logic [15:0] expData,
  input  logic [15:0] iadOut,
  input  logic iadOe,
  output int errCount,
  output int checkCount
);

  // Compare host read data while the read strobe is still low
  always @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      errCount <= 0;
      checkCount <= 0;
    end else if (chkValid) begin
      checkCount <= checkCount + 1;
      if (iadOut !== expData) begin
        $display("Mismatch iadOut: expected %h got %h at %0t", expData, iadOut, $time);
      end
      if (iadOe !== 1'b1) begin
        $display("Mismatch iadOe: expected %h got %h at %0t", 1'b1, iadOe, $time);
      end
      errCount <= errCount + int'(iadOut !== expData) + int'(iadOe !== 1'b1);
    end
  end

endmodule

//--- idmaPkg.sv
package idmaPkg;

  // Auto-increment address in the control word
  localparam int AddrBits = 14;

  localparam int OvlBits = 12;  // Overlay register width

  // Memory model sizes
  localparam int DmDepth = 64;
  localparam int PmAddrBits = 6;
  localparam int PmPageBits = 2;

  // Bit 15 of a latched word picks overlay (1) or control (0)
  localparam int CtlDirBit = 15;

  // Half of a 24-bit program word being moved
  typedef enum logic {
    PhaseHigh,
    PhaseLow
  } WordPhase;

  // Host read/write cycle
  typedef enum logic [1:0] {
    CycIdle,
    CycWait,  // Programmable wait count running
    CycReq,   // Steal request out, waiting for dsAck
    CycDone
  } CycState;

endpackage

//--- idmaRegs.sv
`timescale 1ns/1ps

module idmaRegs import idmaPkg::*; (
  input  logic DSPCLK,
  input  logic RST,
  input  logic ldCtl,
  input  logic ldOvl,
  input  logic incAddr,
  input  logic [15:0] latchWord,
  output logic [AddrBits-1:0] ctlAddr,
  output logic pmSel,
  output logic [OvlBits-1:0] ovl
);

  // Control register with the direction bit just above the address
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      pmSel <= 1'b0;
      ctlAddr <= '0;
    end else if (ldCtl) begin
      pmSel <= latchWord[AddrBits];  // 1 = program memory
      ctlAddr <= latchWord[AddrBits-1:0];
    end else if (incAddr) begin
      ctlAddr <= ctlAddr + 1'b1;  // Wraps at 14 bits
    end
  end

  // Overlay register
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      ovl <= '0;
    end else if (ldOvl) begin
      ovl <= latchWord[OvlBits-1:0];
    end
  end

endmodule

//--- idmaTb.sv
`timescale 1ns/1ps

module idmaTb;

  logic DSPCLK;
  logic RST;
  logic isN;
  logic ialN;
  logic irdN;
  logic iwrN;
  logic coreBusy;
  logic [15:0] iadIn;
  logic [2:0] drWait;
  logic [2:0] dwWait;
  logic iackN;
  logic iadOe;
  logic [15:0] iadOut;
  logic chkValid;
  logic [15:0] expData;
  int monErrors;
  int monChecks;
  int tbErrors;
  int numOps;
  int wdCycles;
  int cycleCnt;
  int busyUntil;
  logic [31:0] traceMem [0:511];

  idmaTop dut0 (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .isN      (isN),
    .ialN     (ialN),
    .irdN     (irdN),
    .iwrN     (iwrN),
    .coreBusy (coreBusy),
    .iadIn    (iadIn),
    .drWait   (drWait),
    .dwWait   (dwWait),
    .iackN    (iackN),
    .iadOe    (iadOe),
    .iadOut   (iadOut)
  );

  idmaMonitor mon0 (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .chkValid   (chkValid),
    .expData    (expData),
    .iadOut     (iadOut),
    .iadOe      (iadOe),
    .errCount   (monErrors),
    .checkCount (monChecks)
  );

  initial DSPCLK = 1'b0;
  always #20 DSPCLK = ~DSPCLK;

  // Core activity window counted in clock cycles
  always @(posedge DSPCLK) begin
    cycleCnt <= cycleCnt + 1;
    coreBusy <= (cycleCnt < busyUntil);
  end

  task automatic idleCycles(input int n);
    repeat (n) @(posedge DSPCLK);
  endtask

  task automatic addrLatch(input logic [15:0] word);
    @(posedge DSPCLK);
    isN <= 1'b0;
    ialN <= 1'b0;
    iadIn <= word;
    @(posedge DSPCLK);
    isN <= 1'b1;
    ialN <= 1'b1;
    idleCycles(3);  // Registers load two cycles after the strobe
  endtask

  // One host read or write that waits for iackN to rise and fall again
  task automatic hostCycle(input logic isWrite, input logic [15:0] data);
    @(posedge DSPCLK);
    isN <= 1'b0;
    if (isWrite) begin
      iwrN <= 1'b0;
      iadIn <= data;
    end else begin
      irdN <= 1'b0;
    end
    @(negedge DSPCLK);
    while (iackN !== 1'b1) @(negedge DSPCLK);
    while (iackN !== 1'b0) @(negedge DSPCLK);
    @(posedge DSPCLK);
    if (!isWrite) begin
      chkValid <= 1'b1;
      expData <= data;
    end
    @(posedge DSPCLK);
    chkValid <= 1'b0;
    isN <= 1'b1;
    irdN <= 1'b1;
    iwrN <= 1'b1;
    idleCycles(1);
  endtask

  initial begin
    RST = 1'b1;
    isN = 1'b1;
    ialN = 1'b1;
    irdN = 1'b1;
    iwrN = 1'b1;
    iadIn = 16'h0000;
    drWait = 3'd0;
    dwWait = 3'd0;
    coreBusy = 1'b0;
    chkValid = 1'b0;
    expData = 16'h0000;
    cycleCnt = 0;
    busyUntil = 0;
    tbErrors = 0;
    numOps = 0;
    wdCycles = 0;
    for (int i = 0; i < 512; i++) begin
      traceMem[i] = 32'h0;
    end
    $readmemh("idmaTrace.txt", traceMem);
    while (numOps < 256 && traceMem[2*numOps] != 32'h0) numOps++;
    if (numOps == 0) begin
      $display("Trace file is empty or missing");
      $display("Testbench failed");
      $finish;
    end else begin
      wdCycles = numOps * 200 + 50;
      repeat (4) @(posedge DSPCLK);
      RST <= 1'b0;
      idleCycles(2);
      for (int i = 0; i < numOps; i++) begin
        case (traceMem[2*i])
          32'd1: addrLatch(traceMem[2*i+1][15:0]);
          32'd2: hostCycle(1'b1, traceMem[2*i+1][15:0]);
          32'd3: hostCycle(1'b0, traceMem[2*i+1][15:0]);
          32'd4: busyUntil <= cycleCnt + int'(traceMem[2*i+1]);
          32'd5: begin
            @(posedge DSPCLK);
            drWait <= traceMem[2*i+1][5:3];
            dwWait <= traceMem[2*i+1][2:0];
          end
          default: begin
            tbErrors++;
            $display("Unknown trace opcode %h on line %0d", traceMem[2*i], i);
          end
        endcase
      end
      idleCycles(4);
      $display("Closing: %0d read checks, %0d errors", monChecks, monErrors + tbErrors);
      if (monErrors + tbErrors == 0 && monChecks > 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // Watchdog allows 200 cycles per trace line
  initial begin
    wait (wdCycles != 0);
    repeat (wdCycles) @(posedge DSPCLK);
    $display("Timeout: trace did not finish in %0d cycles", wdCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- idmaTiming_checker.sv
`timescale 1ns/1ps

module idmaTiming_checker (
  input logic DSPCLK,
  input logic RST,
  input logic dsReq,
  input logic dsAck,
  input logic iackN
);

  // Grant is a single pulse and the request drops right after it
  ackPulse: assert property (@(posedge DSPCLK) disable iff (RST) dsAck |=> !dsAck && !dsReq)
    else $error("dsAck longer than one cycle or dsReq held after dsAck");

  // Request level held until granted
  reqHeld: assert property (@(posedge DSPCLK) disable iff (RST) dsReq && !dsAck |=> dsReq)
    else $error("dsReq dropped before dsAck");

  ackLowAfterReset: assert property (@(posedge DSPCLK) $past(RST) |-> !iackN)
    else $error("iackN not low after reset");

endmodule

bind idmaHostSeq idmaTiming_checker chk0 (
  .DSPCLK (DSPCLK),
  .RST    (RST),
  .dsReq  (mem.dsReq),
  .dsAck  (mem.dsAck),
  .iackN  (iackN)
);

//--- idmaTop.sv
`timescale 1ns/1ps

module idmaTop import idmaPkg::*; (
  input  logic DSPCLK,
  input  logic RST,
  input  logic isN,
  input  logic ialN,
  input  logic irdN,
  input  logic iwrN,
  input  logic coreBusy,
  input  logic [15:0] iadIn,
  input  logic [2:0] drWait,
  input  logic [2:0] dwWait,
  output logic iackN,
  output logic iadOe,
  output logic [15:0] iadOut
);

  logic ldCtl;
  logic ldOvl;
  logic incAddr;
  logic [15:0] latchWord;
  logic [AddrBits-1:0] ctlAddr;
  logic pmSel;
  logic [OvlBits-1:0] ovl;

  idmaMemIf memIf0 ();

  idmaRegs regs0 (
    .DSPCLK    (DSPCLK),
    .RST       (RST),
    .ldCtl     (ldCtl),
    .ldOvl     (ldOvl),
    .incAddr   (incAddr),
    .latchWord (latchWord),
    .ctlAddr   (ctlAddr),
    .pmSel     (pmSel),
    .ovl       (ovl)
  );

  idmaHostSeq seq0 (
    .DSPCLK    (DSPCLK),
    .RST       (RST),
    .isN       (isN),
    .ialN      (ialN),
    .irdN      (irdN),
    .iwrN      (iwrN),
    .iadIn     (iadIn),
    .drWait    (drWait),
    .dwWait    (dwWait),
    .ctlAddr   (ctlAddr),
    .pmSel     (pmSel),
    .ovl       (ovl),
    .ldCtl     (ldCtl),
    .ldOvl     (ldOvl),
    .incAddr   (incAddr),
    .latchWord (latchWord),
    .iackN     (iackN),
    .iadOut    (iadOut),
    .iadOe     (iadOe),
    .mem       (memIf0.seq)
  );

  idmaMem mem0 (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .coreBusy (coreBusy),
    .mem      (memIf0.mem)
  );

endmodule

//--- idmaTrace.txt
// Host bus trace: each line holds an opcode and a value, both in hex
// 1 latch word, 2 write data, 3 read with expected data, 4 coreBusy cycles, 5 waits {dr,dw}
1 0010
2 1111
2 2222
2 3333
1 0010
3 1111
3 2222
3 3333
// Program memory, high half then low byte
1 4005
2 abcd
2 0012
2 5678
2 009a
1 4005
3 abcd
3 0012
3 5678
3 009a
// Overlay page 1 against page 0 at the same address
1 8001
1 4005
2 1357
2 0024
1 8000
1 4005
3 abcd
3 0012
1 8001
1 4005
3 1357
3 0024
// Core holds memory for 48 cycles
4 0030
1 0010
3 1111
3 2222
// Wait counts of 3 for reads and writes
5 001b
1 8000
1 4010
2 2468
2 00ac
1 4010
3 2468
3 00ac
1 4005
3 abcd
1 4005
3 abcd
3 0012

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module idmaTb -f all.f -o simv
out=$(./obj_dir/simv)
echo "$out"
if echo "$out" | grep -q "Testbench passed"; then
  exit 0
else
  exit 1
fi
